// File: common/rename_pkg.sv
package rename_pkg;

    // Register file sizes
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;

    // Wide enough for any ROB depth up to 16
    localparam int ROB_ID_BITS = 4;

    typedef logic [4:0] arch_reg_t;
    typedef logic [5:0] phys_reg_t;
    typedef logic [ROB_ID_BITS-1:0] rob_id_t;

    // One instruction as it arrives at dispatch
    typedef struct packed {
        logic      has_rd;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
    } dispatch_req_t;

    // Renamed instruction handed to issue
    typedef struct packed {
        phys_reg_t prs1;
        phys_reg_t prs2;
        phys_reg_t prd;
        phys_reg_t old_prd;
        rob_id_t   rob_id;
        // has_rd and rd != x0
        logic      writes_rd;
    } rename_result_t;

    // ROB entry payload, also the retire record
    typedef struct packed {
        rob_id_t   rob_id;
        arch_reg_t rd;
        phys_reg_t prd;
        phys_reg_t old_prd;
        logic      writes_rd;
    } commit_info_t;

endpackage : rename_pkg

// File: rename/rat.sv
`timescale 1ns/10ps

module rat (
    input  logic                  clk,
    input  logic                  rst_n,

    // Update for the dispatching writer
    input  logic                  we,
    input  rename_pkg::arch_reg_t rd,
    input  rename_pkg::phys_reg_t new_prd,

    // Source lookups
    input  rename_pkg::arch_reg_t rs1,
    input  rename_pkg::arch_reg_t rs2,

    output rename_pkg::phys_reg_t prs1,
    output rename_pkg::phys_reg_t prs2,
    output rename_pkg::phys_reg_t old_prd
);

    // Speculative arch to phys mapping
    rename_pkg::phys_reg_t map_q [rename_pkg::ARCH_REGS];

    // Identity map out of reset, x0 stays on p0 forever
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                map_q[i] <= rename_pkg::phys_reg_t'(i);
            end
        end else if (we) begin
            map_q[rd] <= new_prd;
        end
    end

    // Reads see the table before this cycle's update
    assign prs1    = map_q[rs1];
    assign prs2    = map_q[rs2];
    assign old_prd = map_q[rd];

    // x0 must never be remapped, dispatch filters rd == 0
    assert property (@(posedge clk) disable iff (!rst_n) we |-> rd != '0)
        else $error("rat: write to x0 mapping");

endmodule : rat

// File: rename/free_list.sv
`timescale 1ns/10ps

module free_list (
    input  logic                  clk,
    input  logic                  rst_n,

    // Allocation side
    input  logic                  pop,
    output rename_pkg::phys_reg_t head,
    output logic                  empty,

    // Retire side
    input  logic                  push,
    input  rename_pkg::phys_reg_t push_reg
);

    // Everything above the architectural registers starts free
    localparam int FL_DEPTH = rename_pkg::PHYS_REGS - rename_pkg::ARCH_REGS;
    localparam int PTR_BITS = $clog2(FL_DEPTH);

    rename_pkg::phys_reg_t  regs_q [FL_DEPTH];
    logic [PTR_BITS-1:0]    head_q;
    logic [PTR_BITS-1:0]    tail_q;
    logic [PTR_BITS:0]      count_q;
    logic                   full;

    assign head  = regs_q[head_q];
    assign empty = (count_q == '0);
    assign full  = (count_q == (PTR_BITS+1)'(FL_DEPTH));

    // Contents need a known start, so the queue body is reset too
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                regs_q[i] <= rename_pkg::phys_reg_t'(rename_pkg::ARCH_REGS + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= (PTR_BITS+1)'(FL_DEPTH);
        end else begin
            if (push) begin
                regs_q[tail_q] <= push_reg;
                tail_q         <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Pop only with a register in hand, push never past capacity
    assert property (@(posedge clk) disable iff (!rst_n)
        !(pop && empty) && !(push && full))
        else $error("free_list: pop while empty or push while full");

endmodule : free_list

// File: rename/rename_dispatch.sv
`timescale 1ns/10ps

module rename_dispatch #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        dispatch_valid,
    input  rename_pkg::dispatch_req_t   dispatch_req,
    output logic                        dispatch_ready,

    // Free list
    input  rename_pkg::phys_reg_t       fl_head,
    input  logic                        fl_empty,
    output logic                        fl_pop,

    // RAT
    output logic                        rat_we,
    output rename_pkg::arch_reg_t       rat_rd,
    output rename_pkg::arch_reg_t       rat_rs1,
    output rename_pkg::arch_reg_t       rat_rs2,
    input  rename_pkg::phys_reg_t       rat_prs1,
    input  rename_pkg::phys_reg_t       rat_prs2,
    input  rename_pkg::phys_reg_t       rat_old_prd,

    // ROB
    input  logic                        rob_full,
    input  rename_pkg::rob_id_t         rob_tail_id,
    output logic                        rob_alloc,
    output rename_pkg::commit_info_t    rob_alloc_info,

    output logic                        rename_valid,
    output rename_pkg::rename_result_t  rename_out
);

    logic                       ready_en_q;
    logic                       writes_rd;
    logic                       accept;
    rename_pkg::rename_result_t result;

    // Only place where x0 is filtered out
    assign writes_rd = dispatch_req.has_rd && (dispatch_req.rd != '0);

    // Stall on full ROB, or on a writer with no free register
    assign dispatch_ready = ready_en_q && !rob_full && !(writes_rd && fl_empty);
    assign accept         = dispatch_valid && dispatch_ready;

    assign fl_pop    = accept && writes_rd;
    assign rat_we    = fl_pop;
    assign rat_rd    = dispatch_req.rd;
    assign rat_rs1   = dispatch_req.rs1;
    assign rat_rs2   = dispatch_req.rs2;
    assign rob_alloc = accept;

    always_comb begin
        result.prs1      = rat_prs1;
        result.prs2      = rat_prs2;
        result.prd       = writes_rd ? fl_head : '0;
        result.old_prd   = rat_old_prd;
        result.rob_id    = rob_tail_id;
        result.writes_rd = writes_rd;

        rob_alloc_info.rob_id    = result.rob_id;
        rob_alloc_info.rd        = dispatch_req.rd;
        rob_alloc_info.prd       = result.prd;
        rob_alloc_info.old_prd   = result.old_prd;
        rob_alloc_info.writes_rd = writes_rd;
    end

    // Ready comes up one cycle out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_en_q   <= 1'b0;
            rename_valid <= 1'b0;
        end else begin
            ready_en_q   <= 1'b1;
            rename_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rename_out <= result;
        end
    end

    // The ROB tail must name an entry inside the buffer
    assert property (@(posedge clk) disable iff (!rst_n)
        rob_alloc |-> int'(rob_tail_id) < ROB_DEPTH)
        else $error("rename_dispatch: ROB tail ID out of range");

endmodule : rename_dispatch

// File: rob/rob.sv
`timescale 1ns/10ps

module rob #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,

    // Allocation from dispatch
    input  logic                      alloc,
    input  rename_pkg::commit_info_t  alloc_info,
    output rename_pkg::rob_id_t       tail_id,
    output logic                      full,

    // Out of order completion
    input  logic                      complete_valid,
    input  rename_pkg::rob_id_t       complete_rob_id,

    // Release of the previous mapping
    output logic                      free_push,
    output rename_pkg::phys_reg_t     free_reg,

    output logic                      commit_valid,
    output rename_pkg::commit_info_t  commit_out
);

    localparam int IDX_BITS = $clog2(ROB_DEPTH);
    localparam logic [IDX_BITS:0] DEPTH_COUNT = (IDX_BITS+1)'(ROB_DEPTH);

    rename_pkg::commit_info_t entry_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]     valid_q;
    logic [ROB_DEPTH-1:0]     done_q;
    logic [IDX_BITS-1:0]      head_q;
    logic [IDX_BITS-1:0]      tail_q;
    logic [IDX_BITS:0]        count_q;

    logic                     commit_now;
    logic [IDX_BITS-1:0]      complete_idx;

    assign tail_id      = rename_pkg::rob_id_t'(tail_q);
    assign full         = (count_q == DEPTH_COUNT);
    assign complete_idx = complete_rob_id[IDX_BITS-1:0];

    // Head retires once its done bit is already registered
    assign commit_now = valid_q[head_q] && done_q[head_q];
    assign free_push  = commit_now && entry_q[head_q].writes_rd;
    assign free_reg   = entry_q[head_q].old_prd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q      <= '0;
            done_q       <= '0;
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= commit_now;

            if (alloc) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
                tail_q          <= tail_q + 1'b1;
            end

            if (complete_valid) begin
                done_q[complete_idx] <= 1'b1;
            end

            if (commit_now) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end

            case ({alloc, commit_now})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Entry payload and the retire record
    always_ff @(posedge clk) begin
        if (alloc) begin
            entry_q[tail_q] <= alloc_info;
        end
        if (commit_now) begin
            commit_out <= entry_q[head_q];
        end
    end

    // A completion must name a live entry, and only once
    assert property (@(posedge clk) disable iff (!rst_n)
        complete_valid |-> valid_q[complete_idx] && !done_q[complete_idx])
        else $error("rob: completion for idle or finished entry %0d", complete_rob_id);

endmodule : rob

// File: source/rename_core.sv
`timescale 1ns/10ps

module rename_core #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        dispatch_valid,
    input  rename_pkg::dispatch_req_t   dispatch_req,
    output logic                        dispatch_ready,

    output logic                        rename_valid,
    output rename_pkg::rename_result_t  rename_out,

    input  logic                        complete_valid,
    input  rename_pkg::rob_id_t         complete_rob_id,

    output logic                        commit_valid,
    output rename_pkg::commit_info_t    commit_out
);

    // Free list handshake
    rename_pkg::phys_reg_t    fl_head;
    logic                     fl_empty;
    logic                     fl_pop;
    logic                     free_push;
    rename_pkg::phys_reg_t    free_reg;

    // RAT lookup and update
    logic                     rat_we;
    rename_pkg::arch_reg_t    rat_rd;
    rename_pkg::arch_reg_t    rat_rs1;
    rename_pkg::arch_reg_t    rat_rs2;
    rename_pkg::phys_reg_t    rat_prs1;
    rename_pkg::phys_reg_t    rat_prs2;
    rename_pkg::phys_reg_t    rat_old_prd;

    // ROB allocation
    logic                     rob_full;
    rename_pkg::rob_id_t      rob_tail_id;
    logic                     rob_alloc;
    rename_pkg::commit_info_t rob_alloc_info;

    rename_dispatch #(.ROB_DEPTH(ROB_DEPTH)) dispatch_i (
        .clk(clk), .rst_n(rst_n),
        .dispatch_valid(dispatch_valid), .dispatch_req(dispatch_req),
        .dispatch_ready(dispatch_ready),
        .fl_head(fl_head), .fl_empty(fl_empty), .fl_pop(fl_pop),
        .rat_we(rat_we), .rat_rd(rat_rd), .rat_rs1(rat_rs1), .rat_rs2(rat_rs2),
        .rat_prs1(rat_prs1), .rat_prs2(rat_prs2), .rat_old_prd(rat_old_prd),
        .rob_full(rob_full), .rob_tail_id(rob_tail_id),
        .rob_alloc(rob_alloc), .rob_alloc_info(rob_alloc_info),
        .rename_valid(rename_valid), .rename_out(rename_out)
    );

    rat rat_i (
        .clk(clk), .rst_n(rst_n),
        .we(rat_we), .rd(rat_rd), .rs1(rat_rs1), .rs2(rat_rs2),
        .new_prd(fl_head),
        .prs1(rat_prs1), .prs2(rat_prs2), .old_prd(rat_old_prd)
    );

    free_list free_list_i (
        .clk(clk), .rst_n(rst_n),
        .pop(fl_pop), .push(free_push), .push_reg(free_reg),
        .head(fl_head), .empty(fl_empty)
    );

    rob #(.ROB_DEPTH(ROB_DEPTH)) rob_i (
        .clk(clk), .rst_n(rst_n),
        .alloc(rob_alloc), .alloc_info(rob_alloc_info),
        .tail_id(rob_tail_id), .full(rob_full),
        .complete_valid(complete_valid), .complete_rob_id(complete_rob_id),
        .free_push(free_push), .free_reg(free_reg),
        .commit_valid(commit_valid), .commit_out(commit_out)
    );

endmodule : rename_core

// File: tb/rename_model.svh
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// Reference ROB entry with its completion flag
typedef struct packed {
    rename_pkg::commit_info_t info;
    logic                     done;
} model_entry_t;

rename_pkg::phys_reg_t ref_rat [rename_pkg::ARCH_REGS];
rename_pkg::phys_reg_t ref_free [$];
model_entry_t          ref_rob [$];
int                    ref_tail;

function automatic void init_reference();
    ref_free.delete();
    ref_rob.delete();
    for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
        ref_rat[i] = rename_pkg::phys_reg_t'(i);
    end
    // Free registers handed out in ascending order
    for (int i = rename_pkg::ARCH_REGS; i < rename_pkg::PHYS_REGS; i++) begin
        ref_free.push_back(rename_pkg::phys_reg_t'(i));
    end
    ref_tail = 0;
endfunction

// Stall rule: ROB full, or a writer with no free register
function automatic logic ready_expected(rename_pkg::dispatch_req_t req);
    logic writes;
    writes = req.has_rd && (req.rd != '0);
    return (ref_rob.size() < ROB_DEPTH) && !(writes && ref_free.size() == 0);
endfunction

// Sources and old_prd read before the update of rd
function automatic rename_pkg::rename_result_t rename_expected(rename_pkg::dispatch_req_t req);
    rename_pkg::rename_result_t res;
    model_entry_t               ent;
    res.writes_rd = req.has_rd && (req.rd != '0);
    res.prs1      = ref_rat[req.rs1];
    res.prs2      = ref_rat[req.rs2];
    res.old_prd   = ref_rat[req.rd];
    res.prd       = res.writes_rd ? ref_free.pop_front() : '0;
    res.rob_id    = rename_pkg::rob_id_t'(ref_tail);
    ref_tail      = (ref_tail + 1) % ROB_DEPTH;
    if (res.writes_rd) begin
        ref_rat[req.rd] = res.prd;
    end
    ent.info.rob_id    = res.rob_id;
    ent.info.rd        = req.rd;
    ent.info.prd       = res.prd;
    ent.info.old_prd   = res.old_prd;
    ent.info.writes_rd = res.writes_rd;
    ent.done           = 1'b0;
    ref_rob.push_back(ent);
    return res;
endfunction

// Oldest entry leaves, its previous mapping goes to the back of the FIFO
function automatic rename_pkg::commit_info_t retire_expected();
    model_entry_t ent;
    ent = ref_rob.pop_front();
    if (ent.info.writes_rd) begin
        ref_free.push_back(ent.info.old_prd);
    end
    return ent.info;
endfunction

// Open entry with this ROB ID becomes done
function automatic void mark_complete(rename_pkg::rob_id_t id);
    foreach (ref_rob[i]) begin
        if (ref_rob[i].info.rob_id == id && !ref_rob[i].done) begin
            ref_rob[i].done = 1'b1;
            return;
        end
    end
endfunction

function automatic int open_count();
    int n;
    n = 0;
    foreach (ref_rob[i]) begin
        if (!ref_rob[i].done) begin
            n++;
        end
    end
    return n;
endfunction

// ROB ID of the k-th entry still waiting for completion
function automatic rename_pkg::rob_id_t open_id(int k);
    int n;
    n = 0;
    foreach (ref_rob[i]) begin
        if (!ref_rob[i].done) begin
            if (n == k) begin
                return ref_rob[i].info.rob_id;
            end
            n++;
        end
    end
    return '0;
endfunction

`endif

// File: tb/rename_tb.sv
`timescale 1ns/10ps

module rename_tb;

    localparam int ROB_DEPTH    = 8;
    localparam int NUM_DISPATCH = 400;
    localparam int TIMEOUT      = NUM_DISPATCH * ROB_DEPTH * 4;

    logic                       clk;
    logic                       rst_n;
    logic                       dispatch_valid;
    rename_pkg::dispatch_req_t  dispatch_req;
    logic                       dispatch_ready;
    logic                       rename_valid;
    rename_pkg::rename_result_t rename_out;
    logic                       complete_valid;
    rename_pkg::rob_id_t        complete_rob_id;
    logic                       commit_valid;
    rename_pkg::commit_info_t   commit_out;

    int                         errors;
    int                         cycles;
    int                         dispatched;
    int                         full_stalls;
    logic                       ready_en;
    logic                       last_accept;
    logic                       exp_rename_valid;
    rename_pkg::rename_result_t exp_rename;
    logic                       exp_commit_valid;
    rename_pkg::commit_info_t   exp_commit;
    logic [15:0]                lfsr_state;

    `include "rename_model.svh"

    rename_core #(.ROB_DEPTH(ROB_DEPTH)) UUT (
        .clk(clk), .rst_n(rst_n),
        .dispatch_valid(dispatch_valid), .dispatch_req(dispatch_req),
        .dispatch_ready(dispatch_ready),
        .rename_valid(rename_valid), .rename_out(rename_out),
        .complete_valid(complete_valid), .complete_rob_id(complete_rob_id),
        .commit_valid(commit_valid), .commit_out(commit_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] random_bits(int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    // Runs at the edge on pre-edge values, then advances the model
    task automatic step_edge();
        logic commit_now;
        check("rename_valid", 32'(rename_valid), 32'(exp_rename_valid));
        if (exp_rename_valid) begin
            check("rename_out", 32'(rename_out), 32'(exp_rename));
        end
        check("commit_valid", 32'(commit_valid), 32'(exp_commit_valid));
        if (exp_commit_valid) begin
            check("commit_out", 32'(commit_out), 32'(exp_commit));
        end
        check("dispatch_ready", 32'(dispatch_ready),
              32'(ready_en && ready_expected(dispatch_req)));
        if (ready_en && !dispatch_ready && ref_rob.size() == ROB_DEPTH) begin
            full_stalls++;
        end
        last_accept = dispatch_valid && dispatch_ready;
        commit_now  = (ref_rob.size() > 0) && ref_rob[0].done;
        if (complete_valid) begin
            mark_complete(complete_rob_id);
        end
        exp_rename_valid = last_accept;
        if (last_accept) begin
            exp_rename = rename_expected(dispatch_req);
            dispatched++;
        end
        exp_commit_valid = commit_now;
        if (commit_now) begin
            exp_commit = retire_expected();
        end
        ready_en = 1'b1;
    endtask

    task automatic drive_inputs();
        rename_pkg::dispatch_req_t req;
        int                        open;
        // Unaccepted request stays on the bus
        if (!(dispatch_valid && !last_accept)) begin
            if (dispatched < NUM_DISPATCH && random_bits(2) != 0) begin
                req.has_rd      = 1'(random_bits(1));
                req.rd          = rename_pkg::arch_reg_t'(random_bits(5));
                req.rs1         = rename_pkg::arch_reg_t'(random_bits(5));
                req.rs2         = rename_pkg::arch_reg_t'(random_bits(5));
                dispatch_req   <= req;
                dispatch_valid <= 1'b1;
            end else begin
                dispatch_valid <= 1'b0;
            end
        end
        // Completions withheld for a while so the ROB fills up
        open = open_count();
        if (!(cycles >= 200 && cycles < 260) && open > 0 && random_bits(1) != 0) begin
            complete_rob_id <= open_id(int'(random_bits(4) % open));
            complete_valid  <= 1'b1;
        end else begin
            complete_valid <= 1'b0;
        end
    endtask

    initial begin
        rst_n            = 1'b0;
        dispatch_valid   = 1'b0;
        dispatch_req     = '0;
        complete_valid   = 1'b0;
        complete_rob_id  = '0;
        lfsr_state       = 16'd11;
        errors           = 0;
        cycles           = 0;
        dispatched       = 0;
        full_stalls      = 0;
        ready_en         = 1'b0;
        last_accept      = 1'b0;
        exp_rename_valid = 1'b0;
        exp_commit_valid = 1'b0;
        init_reference();

        @(posedge clk);
        repeat (7) begin
            @(posedge clk);
            check("dispatch_ready", 32'(dispatch_ready), 32'd0);
            check("rename_valid", 32'(rename_valid), 32'd0);
            check("commit_valid", 32'(commit_valid), 32'd0);
        end
        rst_n <= 1'b1;

        while (!(dispatched == NUM_DISPATCH && ref_rob.size() == 0 && !exp_commit_valid
                 && !exp_rename_valid) && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
            step_edge();
            drive_inputs();
        end

        if (cycles >= TIMEOUT) begin
            errors++;
            $display("Run hung: %0d cycles with %0d of %0d dispatched",
                     cycles, dispatched, NUM_DISPATCH);
        end
        if (full_stalls == 0) begin
            errors++;
            $display("Dispatch never stalled on a full ROB");
        end
        $display("%0d dispatches, %0d cycles, %0d errors", dispatched, cycles, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : rename_tb

// File: rename_core.f
+incdir+tb
common/rename_pkg.sv
rename/rat.sv
rename/free_list.sv
rename/rename_dispatch.sv
rob/rob.sv
source/rename_core.sv
tb/rename_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the rename_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    --top-module rename_tb \
    --Mdir obj_dir \
    -o rename_sim \
    -f rename_core.f

./obj_dir/rename_sim | tee sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
